// File: design/rv_isa_pkg.sv
/* rv_isa_pkg: rv32im instruction-set constants
   opcodes, fixed system encodings and the basic word types */
package rv_isa_pkg;

    typedef logic [31:0] inst_t;      // raw instruction word
    typedef logic [31:0] addr_t;      // instruction address
    typedef logic [31:0] xlen_t;      // register data word
    typedef logic [4:0]  reg_addr_t;  // x0..x31
    typedef logic [11:0] csr_addr_t;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // whole-word encodings matched exactly
    localparam inst_t INST_NOP    = 32'h0000_0013;  // addi x0, x0, 0
    localparam inst_t INST_ECALL  = 32'h0000_0073;
    localparam inst_t INST_EBREAK = 32'h0010_0073;
    localparam inst_t INST_MRET   = 32'h3020_0073;
    localparam inst_t INST_DRET   = 32'h7b20_0073;

endpackage

// File: design/decinfo_pkg.sv
/* decinfo_pkg: layout of the grouped decode-information bus
   group codes in bits 2..0, per-group flags from bit 3 upward */
package decinfo_pkg;

    localparam int DECINFO_GRP_W = 3;
    localparam int DECINFO_W     = 19;  // widest group is csr

    typedef logic [DECINFO_W-1:0] decinfo_t;

    localparam logic [DECINFO_GRP_W-1:0] GRP_ALU    = 3'd1;
    localparam logic [DECINFO_GRP_W-1:0] GRP_BJP    = 3'd2;
    localparam logic [DECINFO_GRP_W-1:0] GRP_MULDIV = 3'd3;
    localparam logic [DECINFO_GRP_W-1:0] GRP_CSR    = 3'd4;
    localparam logic [DECINFO_GRP_W-1:0] GRP_MEM    = 3'd5;
    localparam logic [DECINFO_GRP_W-1:0] GRP_SYS    = 3'd6;

    // group widths including the group code
    localparam int ALU_W = 17;
    localparam int BJP_W = 11;
    localparam int MD_W  = 13;
    localparam int CSR_W = 19;
    localparam int MEM_W = 13;
    localparam int SYS_W = 9;

    // flag positions
    localparam int ALU_LUI = 3, ALU_AUIPC = 4, ALU_ADD = 5, ALU_SUB = 6, ALU_SLL = 7;
    localparam int ALU_SLT = 8, ALU_SLTU = 9, ALU_XOR = 10, ALU_SRL = 11, ALU_SRA = 12;
    localparam int ALU_OR = 13, ALU_AND = 14, ALU_OP2IMM = 15, ALU_OP1PC = 16;
    localparam int BJP_JUMP = 3, BJP_BEQ = 4, BJP_BNE = 5, BJP_BLT = 6, BJP_BGE = 7;
    localparam int BJP_BLTU = 8, BJP_BGEU = 9, BJP_OP1RS1 = 10;
    localparam int MD_MUL = 3, MD_MULH = 4, MD_MULHSU = 5, MD_MULHU = 6, MD_DIV = 7;
    localparam int MD_DIVU = 8, MD_REM = 9, MD_REMU = 10, MD_OP_MUL = 11, MD_OP_DIV = 12;
    localparam int CSR_CSRRW = 3, CSR_CSRRS = 4, CSR_CSRRC = 5, CSR_RS1IMM = 6;
    localparam int CSR_ADDR_LSB = 7;  // csr address up to bit 18
    localparam int MEM_LB = 3, MEM_LH = 4, MEM_LW = 5, MEM_LBU = 6, MEM_LHU = 7;
    localparam int MEM_SB = 8, MEM_SH = 9, MEM_SW = 10, MEM_OP_LOAD = 11, MEM_OP_STORE = 12;
    localparam int SYS_ECALL = 3, SYS_EBREAK = 4, SYS_NOP = 5, SYS_MRET = 6;
    localparam int SYS_DRET = 7, SYS_FENCE = 8;

endpackage

// File: design/dec_out_if.sv
/* dec_out_if: decoder results toward the register file and the
   decode/execute register */
`timescale 1ns/1ps

interface dec_out_if import rv_isa_pkg::*, decinfo_pkg::*; ();
    xlen_t     imm;
    decinfo_t  info;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    logic      reg_we;
    reg_addr_t reg_waddr;
    logic      csr_we;
    csr_addr_t csr_addr;

    modport dec (output imm, info, rs1_addr, rs2_addr, reg_we, reg_waddr, csr_we, csr_addr);
    modport rf  (input rs1_addr, rs2_addr);
    modport ex  (input imm, info, rs1_addr, rs2_addr, reg_we, reg_waddr, csr_we, csr_addr);
endinterface

// File: design/if_id_reg.sv
/* if_id_reg: fetch/decode pipeline register with valid bit */
`timescale 1ns/1ps

module if_id_reg import rv_isa_pkg::*; (
    input  logic  clk,
    input  logic  rst_i,
    input  logic  inst_valid_i,  // one-cycle fetch strobe
    input  inst_t inst_i,
    input  addr_t inst_addr_i,
    output logic  valid_o,
    output inst_t inst_o,
    output addr_t inst_addr_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o     <= 1'b0;
            inst_o      <= '0;  // all-zero word decodes as illegal
            inst_addr_o <= '0;
        end else begin
            valid_o <= inst_valid_i;  // high for one cycle per strobe
            if (inst_valid_i) begin
                inst_o      <= inst_i;
                inst_addr_o <= inst_addr_i;
            end
        end
    end

endmodule

// File: design/idu_decode.sv
/* idu_decode: combinational rv32im decoder
   immediate select, grouped decode info and register/csr controls */
`timescale 1ns/1ps

module idu_decode
    import rv_isa_pkg::*;
    import decinfo_pkg::*;
(
    input  inst_t  inst_i,
    dec_out_if.dec dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [7:0] f3;  // funct3 one-hot

    logic is_lui, is_auipc, is_jal, is_jalr, is_branch, is_load, is_store;
    logic is_opimm, is_op, is_fence, is_fence_i, is_system;
    logic r_base, r_alt, i_base, i_alt, is_md, is_csr, csr_imm, alu_imm;
    logic inst_nop, inst_ecall, inst_ebreak, inst_mret, inst_dret;
    logic op_alu, op_bjp, op_mem, op_sys;
    logic use_rs1, use_rs2, use_rd;

    logic [ALU_W-1:0] alu_bus;
    logic [BJP_W-1:0] bjp_bus;
    logic [MD_W-1:0]  md_bus;
    logic [CSR_W-1:0] csr_bus;
    logic [MEM_W-1:0] mem_bus;
    logic [SYS_W-1:0] sys_bus;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign f3     = 8'b1 << funct3;

    assign is_lui     = (opcode == OPC_LUI);
    assign is_auipc   = (opcode == OPC_AUIPC);
    assign is_jal     = (opcode == OPC_JAL);
    assign is_jalr    = (opcode == OPC_JALR) & f3[0];
    assign is_branch  = (opcode == OPC_BRANCH);
    assign is_load    = (opcode == OPC_LOAD);
    assign is_store   = (opcode == OPC_STORE);
    assign is_opimm   = (opcode == OPC_OPIMM);
    assign is_op      = (opcode == OPC_OP);
    assign is_fence   = (opcode == OPC_FENCE) & f3[0];
    assign is_fence_i = (opcode == OPC_FENCE) & f3[1];
    assign is_system  = (opcode == OPC_SYSTEM);

    assign r_base  = is_op & (funct7 == 7'b0000000);
    assign r_alt   = is_op & (funct7 == 7'b0100000);  // sub / sra
    assign is_md   = is_op & (funct7 == 7'b0000001);
    assign i_base  = is_opimm & (funct7 == 7'b0000000);  // slli / srli
    assign i_alt   = is_opimm & (funct7 == 7'b0100000);  // srai
    assign is_csr  = is_system & (funct3[1:0] != 2'b00);
    assign csr_imm = is_csr & funct3[2];

    assign inst_nop    = (inst_i == INST_NOP);
    assign inst_ecall  = (inst_i == INST_ECALL);
    assign inst_ebreak = (inst_i == INST_EBREAK);
    assign inst_mret   = (inst_i == INST_MRET);
    assign inst_dret   = (inst_i == INST_DRET);
    assign alu_imm     = is_opimm & ~inst_nop;  // nop goes to the sys group

    // immediate select, sources are mutually exclusive
    always_comb begin
        if (is_lui || is_auipc)
            dec_o.imm = {inst_i[31:12], 12'b0};
        else if (is_jal)
            dec_o.imm = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
        else if (is_branch)
            dec_o.imm = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
        else if (is_store)
            dec_o.imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
        else if (csr_imm)
            dec_o.imm = {27'b0, inst_i[19:15]};  // zimm
        else if (is_opimm && (f3[1] || f3[5]))
            dec_o.imm = {27'b0, inst_i[24:20]};  // shamt
        else if (is_opimm || is_load || is_jalr)
            dec_o.imm = {{20{inst_i[31]}}, inst_i[31:20]};
        else
            dec_o.imm = '0;
    end

    always_comb begin
        alu_bus[DECINFO_GRP_W-1:0] = GRP_ALU;
        alu_bus[ALU_LUI]    = is_lui;
        alu_bus[ALU_AUIPC]  = is_auipc;
        alu_bus[ALU_ADD]    = (alu_imm | r_base) & f3[0];
        alu_bus[ALU_SUB]    = r_alt & f3[0];
        alu_bus[ALU_SLL]    = (i_base | r_base) & f3[1];
        alu_bus[ALU_SLT]    = (is_opimm | r_base) & f3[2];
        alu_bus[ALU_SLTU]   = (is_opimm | r_base) & f3[3];
        alu_bus[ALU_XOR]    = (is_opimm | r_base) & f3[4];
        alu_bus[ALU_SRL]    = (i_base | r_base) & f3[5];
        alu_bus[ALU_SRA]    = (i_alt | r_alt) & f3[5];
        alu_bus[ALU_OR]     = (is_opimm | r_base) & f3[6];
        alu_bus[ALU_AND]    = (is_opimm | r_base) & f3[7];
        alu_bus[ALU_OP2IMM] = is_opimm | is_lui | is_auipc;
        alu_bus[ALU_OP1PC]  = is_auipc;

        bjp_bus[DECINFO_GRP_W-1:0] = GRP_BJP;
        bjp_bus[BJP_JUMP]   = is_jal | is_jalr;
        bjp_bus[BJP_BEQ]    = is_branch & f3[0];
        bjp_bus[BJP_BNE]    = is_branch & f3[1];
        bjp_bus[BJP_BLT]    = is_branch & f3[4];
        bjp_bus[BJP_BGE]    = is_branch & f3[5];
        bjp_bus[BJP_BLTU]   = is_branch & f3[6];
        bjp_bus[BJP_BGEU]   = is_branch & f3[7];
        bjp_bus[BJP_OP1RS1] = is_jalr;

        md_bus[DECINFO_GRP_W-1:0] = GRP_MULDIV;
        md_bus[MD_MUL]    = is_md & f3[0];
        md_bus[MD_MULH]   = is_md & f3[1];
        md_bus[MD_MULHSU] = is_md & f3[2];
        md_bus[MD_MULHU]  = is_md & f3[3];
        md_bus[MD_DIV]    = is_md & f3[4];
        md_bus[MD_DIVU]   = is_md & f3[5];
        md_bus[MD_REM]    = is_md & f3[6];
        md_bus[MD_REMU]   = is_md & f3[7];
        md_bus[MD_OP_MUL] = is_md & ~funct3[2];
        md_bus[MD_OP_DIV] = is_md & funct3[2];

        csr_bus[DECINFO_GRP_W-1:0] = GRP_CSR;
        csr_bus[CSR_CSRRW]  = is_csr & (funct3[1:0] == 2'b01);
        csr_bus[CSR_CSRRS]  = is_csr & (funct3[1:0] == 2'b10);
        csr_bus[CSR_CSRRC]  = is_csr & (funct3[1:0] == 2'b11);
        csr_bus[CSR_RS1IMM] = csr_imm;
        csr_bus[CSR_W-1:CSR_ADDR_LSB] = inst_i[31:20];

        mem_bus[DECINFO_GRP_W-1:0] = GRP_MEM;
        mem_bus[MEM_LB]       = is_load & f3[0];
        mem_bus[MEM_LH]       = is_load & f3[1];
        mem_bus[MEM_LW]       = is_load & f3[2];
        mem_bus[MEM_LBU]      = is_load & f3[4];
        mem_bus[MEM_LHU]      = is_load & f3[5];
        mem_bus[MEM_SB]       = is_store & f3[0];
        mem_bus[MEM_SH]       = is_store & f3[1];
        mem_bus[MEM_SW]       = is_store & f3[2];
        mem_bus[MEM_OP_LOAD]  = is_load;
        mem_bus[MEM_OP_STORE] = is_store;

        sys_bus[DECINFO_GRP_W-1:0] = GRP_SYS;
        sys_bus[SYS_ECALL]  = inst_ecall;
        sys_bus[SYS_EBREAK] = inst_ebreak;
        sys_bus[SYS_NOP]    = inst_nop;
        sys_bus[SYS_MRET]   = inst_mret;
        sys_bus[SYS_DRET]   = inst_dret;
        sys_bus[SYS_FENCE]  = is_fence | is_fence_i;
    end

    assign op_alu = is_lui | is_auipc | alu_imm | (is_op & ~is_md);
    assign op_bjp = is_jal | is_jalr | is_branch;
    assign op_mem = is_load | is_store;
    assign op_sys = inst_ecall | inst_ebreak | inst_nop | inst_mret | inst_dret
                  | is_fence | is_fence_i;

    // one active group, zero-extended; illegal stays all zero
    always_comb begin
        dec_o.info = '0;
        if (op_alu)
            dec_o.info = decinfo_t'(alu_bus);
        else if (op_bjp)
            dec_o.info = decinfo_t'(bjp_bus);
        else if (is_md)
            dec_o.info = decinfo_t'(md_bus);
        else if (is_csr)
            dec_o.info = decinfo_t'(csr_bus);
        else if (op_mem)
            dec_o.info = decinfo_t'(mem_bus);
        else if (op_sys)
            dec_o.info = decinfo_t'(sys_bus);
    end

    assign use_rs1 = is_jalr | is_branch | is_load | is_store | alu_imm | is_op
                   | (is_csr & ~funct3[2]);
    assign use_rs2 = is_op | is_store | is_branch;
    assign use_rd  = is_lui | is_auipc | is_jal | is_jalr | is_load | alu_imm | is_op | is_csr;

    assign dec_o.rs1_addr  = use_rs1 ? inst_i[19:15] : '0;
    assign dec_o.rs2_addr  = use_rs2 ? inst_i[24:20] : '0;
    assign dec_o.reg_we    = use_rd;
    assign dec_o.reg_waddr = use_rd ? inst_i[11:7] : '0;
    assign dec_o.csr_we    = is_system;  // every system-opcode word
    assign dec_o.csr_addr  = is_system ? inst_i[31:20] : '0;

endmodule

// File: design/regs.sv
/* regs: 32 x 32 general register file
   two asynchronous read ports, one synchronous write port, x0 reads zero */
`timescale 1ns/1ps

module regs import rv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  xlen_t     wdata_i,
    dec_out_if.rf     dec_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o
);

    xlen_t regs_q [0:31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;  // x0 never written
        end
    end

    // reads see a write from the edge that performs it
    assign rs1_data_o = (dec_i.rs1_addr == '0) ? '0 : regs_q[dec_i.rs1_addr];
    assign rs2_data_o = (dec_i.rs2_addr == '0) ? '0 : regs_q[dec_i.rs2_addr];

endmodule

// File: design/id_ex_reg.sv
/* id_ex_reg: decode/execute pipeline register
   holds decode results and operand values for the execute stage */
`timescale 1ns/1ps

module id_ex_reg
    import rv_isa_pkg::*;
    import decinfo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      valid_i,
    input  addr_t     inst_addr_i,
    dec_out_if.ex     dec_i,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,
    output logic      ex_valid_o,
    output addr_t     inst_addr_o,
    output xlen_t     imm_o,
    output decinfo_t  info_o,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output logic      csr_we_o,
    output csr_addr_t csr_addr_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ex_valid_o  <= 1'b0;
            inst_addr_o <= '0;
            imm_o       <= '0;
            info_o      <= '0;
            rs1_data_o  <= '0;
            rs2_data_o  <= '0;
            reg_we_o    <= 1'b0;
            reg_waddr_o <= '0;
            csr_we_o    <= 1'b0;
            csr_addr_o  <= '0;
        end else begin
            ex_valid_o  <= valid_i;
            inst_addr_o <= inst_addr_i;
            imm_o       <= dec_i.imm;
            info_o      <= dec_i.info;
            rs1_data_o  <= rs1_data_i;
            rs2_data_o  <= rs2_data_i;
            reg_we_o    <= valid_i & dec_i.reg_we;  // bubbles carry no write
            reg_waddr_o <= dec_i.reg_waddr;
            csr_we_o    <= valid_i & dec_i.csr_we;
            csr_addr_o  <= dec_i.csr_addr;
        end
    end

endmodule

// File: design/idu_top.sv
/* idu_top: instruction-decode stage
   fetch/decode register, decoder, register file and decode/execute register */
`timescale 1ns/1ps

module idu_top
    import rv_isa_pkg::*;
    import decinfo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  logic      inst_valid_i,
    input  inst_t     inst_i,
    input  addr_t     inst_addr_i,
    input  logic      wb_we_i,     // writeback strobe
    input  reg_addr_t wb_waddr_i,
    input  xlen_t     wb_wdata_i,
    output logic      ex_valid_o,
    output addr_t     inst_addr_o,
    output xlen_t     imm_o,
    output decinfo_t  info_o,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,
    output logic      reg_we_o,
    output reg_addr_t reg_waddr_o,
    output logic      csr_we_o,
    output csr_addr_t csr_addr_o
);

    logic  id_valid;
    inst_t id_inst;
    addr_t id_inst_addr;
    xlen_t rs1_data;
    xlen_t rs2_data;

    dec_out_if dec_bus ();

    if_id_reg i_if_id (
        .clk          (clk),
        .rst_i        (rst_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .inst_addr_i  (inst_addr_i),
        .valid_o      (id_valid),
        .inst_o       (id_inst),
        .inst_addr_o  (id_inst_addr)
    );

    idu_decode i_decode (
        .inst_i (id_inst),
        .dec_o  (dec_bus.dec)
    );

    regs i_regs (
        .clk        (clk),
        .rst_i      (rst_i),
        .we_i       (wb_we_i),
        .waddr_i    (wb_waddr_i),
        .wdata_i    (wb_wdata_i),
        .dec_i      (dec_bus.rf),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_ex_reg i_id_ex (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (id_valid),
        .inst_addr_i (id_inst_addr),
        .dec_i       (dec_bus.ex),
        .rs1_data_i  (rs1_data),
        .rs2_data_i  (rs2_data),
        .ex_valid_o  (ex_valid_o),
        .inst_addr_o (inst_addr_o),
        .imm_o       (imm_o),
        .info_o      (info_o),
        .rs1_data_o  (rs1_data_o),
        .rs2_data_o  (rs2_data_o),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .csr_we_o    (csr_we_o),
        .csr_addr_o  (csr_addr_o)
    );

endmodule

// File: testbench/tb_idu.sv
/* tb_idu: table-driven testbench for the decode stage
   preloads the register file, then runs an instruction table through it */
`timescale 1ns/1ps

module tb_idu
    import rv_isa_pkg::*;
    import decinfo_pkg::*;
();

    localparam int WAIT_LIMIT = 20;  // cycles
    localparam int IDX_SUB    = 3;
    localparam int IDX_MUL    = 11;
    localparam int IDX_ADD0   = 20;  // add x3, x0, x0

    typedef struct packed {
        inst_t     inst;
        xlen_t     imm;
        decinfo_t  info;
        reg_addr_t rs1;  // 0 when the source is unused
        reg_addr_t rs2;
        logic      reg_we;
        reg_addr_t waddr;
        logic      csr_we;
        csr_addr_t csr_addr;
    } entry_t;

    logic      clk;
    logic      rst_i;
    logic      inst_valid_i;
    inst_t     inst_i;
    addr_t     inst_addr_i;
    logic      wb_we_i;
    reg_addr_t wb_waddr_i;
    xlen_t     wb_wdata_i;
    logic      ex_valid_o;
    addr_t     inst_addr_o;
    xlen_t     imm_o;
    decinfo_t  info_o;
    xlen_t     rs1_data_o;
    xlen_t     rs2_data_o;
    logic      reg_we_o;
    reg_addr_t reg_waddr_o;
    logic      csr_we_o;
    csr_addr_t csr_addr_o;

    xlen_t  shadow [0:31];  // expected register file contents
    entry_t table_q [$];

    idu_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("Checks failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_info(input string name, input decinfo_t got, input decinfo_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_csr(input string name, input csr_addr_t got, input csr_addr_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_entry(input inst_t inst, input xlen_t imm, input decinfo_t info,
                             input reg_addr_t rs1, input reg_addr_t rs2, input logic we,
                             input reg_addr_t waddr, input logic cwe, input csr_addr_t caddr);
        table_q.push_back('{inst, imm, info, rs1, rs2, we, waddr, cwe, caddr});
    endtask

    // info values follow the group layout with the code in bits 2..0
    task automatic build_table();
        // addi -4, lui, auipc, sub, srai
        add_entry(32'hffc30293, 32'hfffffffc, 19'h08021, 5'd6, 5'd0, 1'b1, 5'd5, 1'b0, 12'h0);
        add_entry(32'h123453b7, 32'h12345000, 19'h08009, 5'd0, 5'd0, 1'b1, 5'd7, 1'b0, 12'h0);
        add_entry(32'h00001417, 32'h00001000, 19'h18011, 5'd0, 5'd0, 1'b1, 5'd8, 1'b0, 12'h0);
        add_entry(32'h40b504b3, 32'h00000000, 19'h00041, 5'd10, 5'd11, 1'b1, 5'd9, 1'b0, 12'h0);
        add_entry(32'h4036d613, 32'h00000003, 19'h09001, 5'd13, 5'd0, 1'b1, 5'd12, 1'b0, 12'h0);
        // jal, jalr, beq -16
        add_entry(32'h008000ef, 32'h00000008, 19'h0000a, 5'd0, 5'd0, 1'b1, 5'd1, 1'b0, 12'h0);
        add_entry(32'h00c100e7, 32'h0000000c, 19'h0040a, 5'd2, 5'd0, 1'b1, 5'd1, 1'b0, 12'h0);
        add_entry(32'hfe4188e3, 32'hfffffff0, 19'h00012, 5'd3, 5'd4, 1'b0, 5'd0, 1'b0, 12'h0);
        // lw, sb -1, sw
        add_entry(32'h0087a703, 32'h00000008, 19'h00825, 5'd15, 5'd0, 1'b1, 5'd14, 1'b0, 12'h0);
        add_entry(32'hff088fa3, 32'hffffffff, 19'h01105, 5'd17, 5'd16, 1'b0, 5'd0, 1'b0, 12'h0);
        add_entry(32'h0129aa23, 32'h00000014, 19'h01405, 5'd19, 5'd18, 1'b0, 5'd0, 1'b0, 12'h0);
        // mul, remu
        add_entry(32'h036a8a33, 32'h00000000, 19'h0080b, 5'd21, 5'd22, 1'b1, 5'd20, 1'b0, 12'h0);
        add_entry(32'h039c7bb3, 32'h00000000, 19'h01403, 5'd24, 5'd25, 1'b1, 5'd23, 1'b0, 12'h0);
        // csrrw mtvec, csrrsi mstatus with zimm 0x15
        add_entry(32'h305d9d73, 32'h0, 19'h1828c, 5'd27, 5'd0, 1'b1, 5'd26, 1'b1, 12'h305);
        add_entry(32'h300aee73, 32'h15, 19'h18054, 5'd0, 5'd0, 1'b1, 5'd28, 1'b1, 12'h300);
        // ecall, mret, nop, fence, illegal opcode, add x3 x0 x0
        add_entry(32'h00000073, 32'h0, 19'h0000e, 5'd0, 5'd0, 1'b0, 5'd0, 1'b1, 12'h000);
        add_entry(32'h30200073, 32'h0, 19'h00046, 5'd0, 5'd0, 1'b0, 5'd0, 1'b1, 12'h302);
        add_entry(32'h00000013, 32'h0, 19'h00026, 5'd0, 5'd0, 1'b0, 5'd0, 1'b0, 12'h000);
        add_entry(32'h0ff0000f, 32'h0, 19'h00106, 5'd0, 5'd0, 1'b0, 5'd0, 1'b0, 12'h000);
        add_entry(32'hffffffff, 32'h0, 19'h00000, 5'd0, 5'd0, 1'b0, 5'd0, 1'b0, 12'h000);
        add_entry(32'h000001b3, 32'h0, 19'h00021, 5'd0, 5'd0, 1'b1, 5'd3, 1'b0, 12'h000);
    endtask

    task automatic write_reg(input reg_addr_t addr, input xlen_t data);
        @(negedge clk);
        wb_we_i    = 1'b1;
        wb_waddr_i = addr;
        wb_wdata_i = data;
        @(negedge clk);
        wb_we_i = 1'b0;
        if (addr != '0)
            shadow[addr] = data;  // x0 keeps reading zero
    endtask

    task automatic preload_regs();
        logic [31:0] seed;
        seed = 32'hd01d;
        for (int i = 1; i < 32; i++) begin
            seed = next_rand(seed);
            write_reg(reg_addr_t'(i), seed);
        end
    endtask

    task automatic drive_inst(input entry_t e, input addr_t addr);
        @(negedge clk);
        inst_valid_i = 1'b1;
        inst_i       = e.inst;
        inst_addr_i  = addr;
    endtask

    task automatic release_inst();
        @(negedge clk);
        inst_valid_i = 1'b0;
    endtask

    task automatic wait_ex_valid();
        int cycles;
        cycles = 0;
        while (ex_valid_o !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout: ex_valid_o never rose after an instruction strobe");
                abort_run();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_entry(input entry_t e, input addr_t addr);
        check_bit("ex_valid_o", ex_valid_o, 1'b1);
        check_word("inst_addr_o", inst_addr_o, addr);
        check_word("imm_o", imm_o, e.imm);
        check_info("info_o", info_o, e.info);
        check_word("rs1_data_o", rs1_data_o, shadow[e.rs1]);
        check_word("rs2_data_o", rs2_data_o, shadow[e.rs2]);
        check_bit("reg_we_o", reg_we_o, e.reg_we);
        check_reg("reg_waddr_o", reg_waddr_o, e.waddr);
        check_bit("csr_we_o", csr_we_o, e.csr_we);
        check_csr("csr_addr_o", csr_addr_o, e.csr_addr);
    endtask

    task automatic run_entry(input entry_t e, input addr_t addr);
        drive_inst(e, addr);
        release_inst();
        wait_ex_valid();
        check_entry(e, addr);
    endtask

    initial begin
        rst_i        = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        inst_addr_i  = '0;
        wb_we_i      = 1'b0;
        wb_waddr_i   = '0;
        wb_wdata_i   = '0;
        shadow[0]    = '0;
        build_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;

        // idle pipeline after reset
        repeat (5) begin
            @(negedge clk);
            check_bit("ex_valid_o", ex_valid_o, 1'b0);
            check_bit("reg_we_o", reg_we_o, 1'b0);
            check_bit("csr_we_o", csr_we_o, 1'b0);
        end

        preload_regs();
        foreach (table_q[i]) begin
            run_entry(table_q[i], addr_t'(32'h1000 + i * 4));
        end

        // two strobes back to back
        drive_inst(table_q[IDX_SUB], 32'h2000);
        drive_inst(table_q[IDX_MUL], 32'h2004);
        release_inst();
        wait_ex_valid();
        check_entry(table_q[IDX_SUB], 32'h2000);
        @(negedge clk);
        check_entry(table_q[IDX_MUL], 32'h2004);
        @(negedge clk);
        check_bit("ex_valid_o", ex_valid_o, 1'b0);

        write_reg(5'd10, 32'hcafe_f00d);  // sub reads x10
        run_entry(table_q[IDX_SUB], 32'h3000);
        write_reg(5'd0, 32'h1234_5678);
        run_entry(table_q[IDX_ADD0], 32'h3004);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: src.f
design/rv_isa_pkg.sv
design/decinfo_pkg.sv
design/dec_out_if.sv
design/if_id_reg.sv
design/idu_decode.sv
design/regs.sv
design/id_ex_reg.sv
design/idu_top.sv
testbench/tb_idu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_idu
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
